/* hw/axil_regs_consts.svh */
`ifndef AXIL_REGS_CONSTS_SVH
`define AXIL_REGS_CONSTS_SVH

// --------------------------------------------------
// register map geometry
// --------------------------------------------------
`define AXIL_REG_COUNT    16
`define AXIL_ADDR_W       32
`define AXIL_DATA_W       32
`define AXIL_IDX_W        4
`define AXIL_BASE_ADDR    32'h0000_0000

// --------------------------------------------------
// bus responses
// --------------------------------------------------
`define AXIL_RESP_OKAY    2'b00
`define AXIL_RESP_ERROR   2'b10
// returned on reads of unmapped or misaligned addresses
`define AXIL_ERR_DATA     32'hDEAD_BEEF

// one bit per register, set = read-only (control, status, config, version)
`define AXIL_RO_MASK      16'h000F
// non-zero reset words, everything else clears
`define AXIL_RST_STATUS   32'hABCD_1234
`define AXIL_RST_VERSION  32'h0001_0000

`endif

/* hw/axil_regs_pkg.sv */
`include "axil_regs_consts.svh"

package axil_regs_pkg;

    // --------------------------------------------------
    // write channel, master to slave
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]   addr;
        logic                      addr_vld;
        logic [`AXIL_DATA_W-1:0]   data;
        logic [`AXIL_DATA_W/8-1:0] strb;
        logic                      data_vld;
        logic                      resp_rdy;
    } axil_wr_req_t;

    // write channel, slave to master
    typedef struct packed {
        logic       addr_rdy;
        logic       data_rdy;
        logic       resp_vld;
        logic [1:0] resp;
    } axil_wr_rsp_t;

    // --------------------------------------------------
    // read channel
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic                    addr_vld;
        logic                    data_rdy;
    } axil_rd_req_t;

    typedef struct packed {
        logic                    addr_rdy;
        logic                    data_vld;
        logic [`AXIL_DATA_W-1:0] data;
        logic [1:0]              resp;
    } axil_rd_rsp_t;

    // decoded address, writable already implies ok
    typedef struct packed {
        logic [`AXIL_IDX_W-1:0] idx;
        logic                   ok;
        logic                   writable;
    } axil_dec_t;

    // single-cycle write strobe into the register file
    typedef struct packed {
        logic                      en;
        logic [`AXIL_IDX_W-1:0]    idx;
        logic [`AXIL_DATA_W-1:0]   data;
        logic [`AXIL_DATA_W/8-1:0] strb;
    } axil_reg_wr_t;

endpackage

/* hw/axil_addr_decode.sv */
`include "axil_regs_consts.svh"

module axil_addr_decode (
    input  logic [`AXIL_ADDR_W-1:0] addr,
    output axil_regs_pkg::axil_dec_t dec
);

    // byte span of the whole register window
    localparam logic [`AXIL_ADDR_W-1:0] SPAN = `AXIL_REG_COUNT * 4;
    localparam logic [`AXIL_REG_COUNT-1:0] RO_MASK = `AXIL_RO_MASK;

    logic [`AXIL_ADDR_W-1:0] offset;
    logic                    aligned;
    logic                    in_range;
    logic [`AXIL_IDX_W-1:0]  idx;

    // addresses below base wrap to a huge offset and fail the range check
    assign offset   = addr - `AXIL_BASE_ADDR;
    assign aligned  = (addr[1:0] == 2'b00);
    assign in_range = (offset < SPAN);

    // word index with the byte lanes dropped
    assign idx      = offset[`AXIL_IDX_W+1:2];

    always_comb begin
        dec.idx      = idx;
        dec.ok       = aligned && in_range;
        // read-only registers reject writes even when mapped
        dec.writable = aligned && in_range && !RO_MASK[idx];
    end

endmodule

/* hw/axil_reg_file.sv */
`include "axil_regs_consts.svh"

module axil_reg_file (
    input  logic                        axi_s,
    input  logic                        rst_n,
    input  axil_regs_pkg::axil_reg_wr_t reg_wr,
    input  logic [`AXIL_IDX_W-1:0]      rd_idx,
    output logic [`AXIL_DATA_W-1:0]     rd_word
);

    localparam int BYTES = `AXIL_DATA_W / 8;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    logic [`AXIL_DATA_W-1:0] regs [`AXIL_REG_COUNT];

    // register map
    // 0 control, ro
    // 1 status, ro
    // 2 config, ro
    // 3 version, ro
    // 4..15 general purpose, rw with byte strobes

    always_ff @(posedge axi_s) begin
        if (!rst_n) begin
            // clear all, then the two non-zero defaults
            for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[1] <= `AXIL_RST_STATUS;
            regs[3] <= `AXIL_RST_VERSION;
        end else if (reg_wr.en) begin
            // legality already settled by the write channel
            for (int b = 0; b < BYTES; b++) begin
                if (reg_wr.strb[b]) begin
                    regs[reg_wr.idx][8*b +: 8] <= reg_wr.data[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    // combinational, so a read racing a write sees the old word
    assign rd_word = regs[rd_idx];

endmodule

/* hw/axil_wr_channel.sv */
`include "axil_regs_consts.svh"

module axil_wr_channel (
    input  logic                        axi_s,
    input  logic                        rst_n,
    input  axil_regs_pkg::axil_wr_req_t wr_req,
    output axil_regs_pkg::axil_wr_rsp_t wr_rsp,
    output logic [`AXIL_ADDR_W-1:0]     wr_addr,
    input  axil_regs_pkg::axil_dec_t    wr_dec,
    output axil_regs_pkg::axil_reg_wr_t reg_wr
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t state;

    // handshake and response flops
    logic       addr_rdy_q;
    logic       data_rdy_q;
    logic       resp_vld_q;
    logic [1:0] resp_q;
    logic       wr_en_q;

    // latched address and write payload
    logic [`AXIL_ADDR_W-1:0]   addr_q;
    logic [`AXIL_IDX_W-1:0]    idx_q;
    logic [`AXIL_DATA_W-1:0]   data_q;
    logic [`AXIL_DATA_W/8-1:0] strb_q;

    logic addr_take;
    logic data_fire;
    logic resp_fire;

    // --------------------------------------------------
    // transfer qualifiers
    // --------------------------------------------------
    assign addr_take = (state == WR_IDLE) && wr_req.addr_vld && !resp_vld_q;
    assign data_fire = (state == WR_DATA) && wr_req.data_vld && data_rdy_q;
    assign resp_fire = (state == WR_RESP) && resp_vld_q && wr_req.resp_rdy;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge axi_s) begin
        if (!rst_n) begin
            state      <= WR_IDLE;
            addr_rdy_q <= 1'b0;
            data_rdy_q <= 1'b0;
            resp_vld_q <= 1'b0;
            resp_q     <= `AXIL_RESP_OKAY;
            wr_en_q    <= 1'b0;
        end else begin
            // addr_rdy is a one-cycle acknowledge of the latched address
            addr_rdy_q <= addr_take;
            // register write only for legal targets, one-cycle pulse
            wr_en_q    <= data_fire && wr_dec.writable;
            data_rdy_q <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (addr_take) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // ready stays up until the data beat lands
                    data_rdy_q <= !data_fire;
                    if (data_fire) begin
                        resp_vld_q <= 1'b1;
                        resp_q     <= wr_dec.writable ? `AXIL_RESP_OKAY : `AXIL_RESP_ERROR;
                        state      <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    // response held untouched under back-pressure
                    if (resp_fire) begin
                        resp_vld_q <= 1'b0;
                        state      <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // payload capture, no reset
    always_ff @(posedge axi_s) begin
        if (addr_take) begin
            addr_q <= wr_req.addr;
        end
        if (data_fire) begin
            idx_q  <= wr_dec.idx;
            data_q <= wr_req.data;
            strb_q <= wr_req.strb;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    // decoder sees the latched address, not the live bus
    assign wr_addr = addr_q;

    always_comb begin
        wr_rsp.addr_rdy = addr_rdy_q;
        wr_rsp.data_rdy = data_rdy_q;
        wr_rsp.resp_vld = resp_vld_q;
        wr_rsp.resp     = resp_q;
        reg_wr.en       = wr_en_q;
        reg_wr.idx      = idx_q;
        reg_wr.data     = data_q;
        reg_wr.strb     = strb_q;
    end

endmodule

/* hw/axil_rd_channel.sv */
`include "axil_regs_consts.svh"

module axil_rd_channel (
    input  logic                        axi_s,
    input  logic                        rst_n,
    input  axil_regs_pkg::axil_rd_req_t rd_req,
    output axil_regs_pkg::axil_rd_rsp_t rd_rsp,
    output logic [`AXIL_ADDR_W-1:0]     rd_addr,
    input  axil_regs_pkg::axil_dec_t    rd_dec,
    output logic [`AXIL_IDX_W-1:0]      rd_idx,
    input  logic [`AXIL_DATA_W-1:0]     rd_word
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_DATA
    } rd_state_t;

    rd_state_t state;

    logic                    addr_rdy_q;
    logic                    data_vld_q;
    logic [`AXIL_DATA_W-1:0] data_q;
    logic [1:0]              resp_q;
    logic [`AXIL_ADDR_W-1:0] addr_q;

    logic addr_take;
    logic data_fire;

    // --------------------------------------------------
    // transfer qualifiers
    // --------------------------------------------------
    assign addr_take = (state == RD_IDLE) && rd_req.addr_vld && !data_vld_q;
    assign data_fire = (state == RD_DATA) && data_vld_q && rd_req.data_rdy;

    // --------------------------------------------------
    // control FSM, read word registered in fetch
    // --------------------------------------------------
    always_ff @(posedge axi_s) begin
        if (!rst_n) begin
            state      <= RD_IDLE;
            addr_rdy_q <= 1'b0;
            data_vld_q <= 1'b0;
            data_q     <= '0;
            resp_q     <= `AXIL_RESP_OKAY;
        end else begin
            addr_rdy_q <= addr_take;
            case (state)
                RD_IDLE: begin
                    if (addr_take) begin
                        state <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    // fixed one cycle after addr_rdy
                    data_q     <= rd_dec.ok ? rd_word : `AXIL_ERR_DATA;
                    resp_q     <= rd_dec.ok ? `AXIL_RESP_OKAY : `AXIL_RESP_ERROR;
                    data_vld_q <= 1'b1;
                    state      <= RD_DATA;
                end
                RD_DATA: begin
                    // data and resp frozen until the master takes them
                    if (data_fire) begin
                        data_vld_q <= 1'b0;
                        state      <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // address latch, no reset
    always_ff @(posedge axi_s) begin
        if (addr_take) begin
            addr_q <= rd_req.addr;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign rd_addr = addr_q;
    assign rd_idx  = rd_dec.idx;

    always_comb begin
        rd_rsp.addr_rdy = addr_rdy_q;
        rd_rsp.data_vld = data_vld_q;
        rd_rsp.data     = data_q;
        rd_rsp.resp     = resp_q;
    end

endmodule

/* hw/axil_regs_top.sv */
`include "axil_regs_consts.svh"

module axil_regs_top (
    input  logic                        axi_s,
    input  logic                        rst_n,
    input  axil_regs_pkg::axil_wr_req_t wr_req,
    output axil_regs_pkg::axil_wr_rsp_t wr_rsp,
    input  axil_regs_pkg::axil_rd_req_t rd_req,
    output axil_regs_pkg::axil_rd_rsp_t rd_rsp
);

    // --------------------------------------------------
    // internal wiring
    // --------------------------------------------------
    logic [`AXIL_ADDR_W-1:0]     wr_addr;
    logic [`AXIL_ADDR_W-1:0]     rd_addr;
    axil_regs_pkg::axil_dec_t    wr_dec;
    axil_regs_pkg::axil_dec_t    rd_dec;
    axil_regs_pkg::axil_reg_wr_t reg_wr;
    logic [`AXIL_IDX_W-1:0]      rd_idx;
    logic [`AXIL_DATA_W-1:0]     rd_word;

    // write side, decoder on the latched address
    axil_wr_channel u_wr_ch (
        .axi_s   (axi_s),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .wr_addr (wr_addr),
        .wr_dec  (wr_dec),
        .reg_wr  (reg_wr)
    );

    axil_addr_decode u_wr_dec (
        .addr (wr_addr),
        .dec  (wr_dec)
    );

    // read side, independent of the write path
    axil_rd_channel u_rd_ch (
        .axi_s   (axi_s),
        .rst_n   (rst_n),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp),
        .rd_addr (rd_addr),
        .rd_dec  (rd_dec),
        .rd_idx  (rd_idx),
        .rd_word (rd_word)
    );

    axil_addr_decode u_rd_dec (
        .addr (rd_addr),
        .dec  (rd_dec)
    );

    // shared storage, one write port and one read port
    axil_reg_file u_reg_file (
        .axi_s   (axi_s),
        .rst_n   (rst_n),
        .reg_wr  (reg_wr),
        .rd_idx  (rd_idx),
        .rd_word (rd_word)
    );

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
    output logic axi_s,
    output logic rst_n
);

    // free-running clock, period 100
    initial begin
        axi_s = 1'b0;
        forever #50 axi_s = ~axi_s;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge axi_s);
        rst_n <= 1'b1;
    end

endmodule

/* verification/axil_regs_checker.sv */
module axil_regs_checker (
    input logic                        axi_s,
    input logic                        rst_n,
    input axil_regs_pkg::axil_wr_req_t wr_req,
    input axil_regs_pkg::axil_wr_rsp_t wr_rsp,
    input axil_regs_pkg::axil_rd_req_t rd_req,
    input axil_regs_pkg::axil_rd_rsp_t rd_rsp
);

    // --------------------------------------------------
    // responses held until accepted
    // --------------------------------------------------
    a_wr_resp_hold: assert property (@(posedge axi_s) disable iff (!rst_n)
        (wr_rsp.resp_vld && !wr_req.resp_rdy) |=> (wr_rsp.resp_vld && $stable(wr_rsp.resp)))
        else $error("write response dropped or changed before acceptance");

    a_rd_data_hold: assert property (@(posedge axi_s) disable iff (!rst_n)
        (rd_rsp.data_vld && !rd_req.data_rdy)
        |=> (rd_rsp.data_vld && $stable(rd_rsp.data) && $stable(rd_rsp.resp)))
        else $error("read data dropped or changed before acceptance");

    // --------------------------------------------------
    // address acknowledge is a single-cycle pulse
    // --------------------------------------------------
    a_wr_addr_pulse: assert property (@(posedge axi_s) disable iff (!rst_n)
        wr_rsp.addr_rdy |=> !wr_rsp.addr_rdy)
        else $error("write addr_rdy high for two cycles");

    a_rd_addr_pulse: assert property (@(posedge axi_s) disable iff (!rst_n)
        rd_rsp.addr_rdy |=> !rd_rsp.addr_rdy)
        else $error("read addr_rdy high for two cycles");

    // read data exactly one cycle after the address acknowledge
    a_rd_latency: assert property (@(posedge axi_s) disable iff (!rst_n)
        rd_rsp.addr_rdy |=> rd_rsp.data_vld)
        else $error("read data_vld missing after addr_rdy");

    a_rd_origin: assert property (@(posedge axi_s) disable iff (!rst_n)
        $rose(rd_rsp.data_vld) |-> $past(rd_rsp.addr_rdy))
        else $error("read data_vld rose without a preceding addr_rdy");

endmodule

bind axil_regs_top axil_regs_checker u_checker (
    .axi_s  (axi_s),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
);

/* verification/tb_axil_regs.sv */
module tb_axil_regs;

    localparam int TXN_LIMIT     = 120;
    localparam int TXN_CYCLES    = 25;
    localparam int WATCHDOG_TIME = TXN_LIMIT * TXN_CYCLES * 100;
    localparam int MIX_N         = 12;

    logic                        axi_s;
    logic                        rst_n;
    axil_regs_pkg::axil_wr_req_t wr_req;
    axil_regs_pkg::axil_wr_rsp_t wr_rsp;
    axil_regs_pkg::axil_rd_req_t rd_req;
    axil_regs_pkg::axil_rd_rsp_t rd_rsp;

    integer seed      = 61;
    int     errors    = 0;
    int     checks    = 0;
    int     wr_issued = 0;
    int     wr_done   = 0;
    int     rd_issued = 0;
    int     rd_done   = 0;

    // shadow register map and expected results in issue order
    logic [31:0] shadow [16];
    logic [31:0] wr_exp_q [$];
    string       wr_name_q [$];
    logic [31:0] rd_exp_data_q [$];
    logic [31:0] rd_exp_resp_q [$];
    string       rd_name_q [$];
    string       rd_name;
    logic [31:0] rnd;
    logic [3:0]  idx4;
    // mixed traffic words, drawn before the fork
    logic [31:0] mix_rnd [3*MIX_N];
    // misaligned or past the last register
    logic [31:0] bad_addr [8] = '{32'h11, 32'h22, 32'h3F, 32'h40, 32'h7C, 32'h1000,
                                  32'hFFFF_FFFC, 32'h02};

    tb_clock_gen u_clk_gen (
        .axi_s (axi_s),
        .rst_n (rst_n)
    );

    axil_regs_top u_dut (
        .axi_s  (axi_s),
        .rst_n  (rst_n),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // --------------------------------------------------
    // reference model of the register map
    // --------------------------------------------------
    function automatic void ref_access(input logic is_wr, input logic [31:0] addr,
                                       input logic [31:0] data, input logic [3:0] strb,
                                       output logic [31:0] resp, output logic [31:0] word);
        logic       valid;
        logic [3:0] idx;
        valid = (addr[1:0] == 2'b00) && (addr < 32'h40);
        idx   = addr[5:2];
        word  = 32'hDEAD_BEEF;
        resp  = 32'h2;
        // regs 0..3 never take writes
        if (is_wr && valid && idx >= 4'd4) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
            resp = 32'h0;
        end else if (!is_wr && valid) begin
            word = shadow[idx];
            resp = 32'h0;
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // --------------------------------------------------
    // master side tasks
    // --------------------------------------------------
    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] dly, input string name);
        logic [31:0] resp;
        logic [31:0] word;
        ref_access(1'b1, addr, data, strb, resp, word);
        wr_exp_q.push_back(resp);
        wr_name_q.push_back(name);
        wr_issued++;
        @(posedge axi_s);
        wr_req.addr     <= addr;
        wr_req.addr_vld <= 1'b1;
        wr_req.data     <= data;
        wr_req.strb     <= strb;
        wr_req.data_vld <= 1'b1;
        // address ack, then data beat
        @(negedge axi_s);
        while (!wr_rsp.addr_rdy) @(negedge axi_s);
        @(posedge axi_s);
        wr_req.addr_vld <= 1'b0;
        @(negedge axi_s);
        while (!wr_rsp.data_rdy) @(negedge axi_s);
        @(posedge axi_s);
        wr_req.data_vld <= 1'b0;
        // stall on resp_rdy
        repeat (dly) @(posedge axi_s);
        wr_req.resp_rdy <= 1'b1;
        @(negedge axi_s);
        while (!wr_rsp.resp_vld) @(negedge axi_s);
        @(posedge axi_s);
        wr_req.resp_rdy <= 1'b0;
    endtask

    task automatic do_read(input logic [31:0] addr, input logic [1:0] dly, input string name);
        logic [31:0] resp;
        logic [31:0] word;
        ref_access(1'b0, addr, 32'h0, 4'h0, resp, word);
        rd_exp_data_q.push_back(word);
        rd_exp_resp_q.push_back(resp);
        rd_name_q.push_back(name);
        rd_issued++;
        @(posedge axi_s);
        rd_req.addr     <= addr;
        rd_req.addr_vld <= 1'b1;
        @(negedge axi_s);
        while (!rd_rsp.addr_rdy) @(negedge axi_s);
        @(posedge axi_s);
        rd_req.addr_vld <= 1'b0;
        repeat (dly) @(posedge axi_s);
        rd_req.data_rdy <= 1'b1;
        @(negedge axi_s);
        while (!rd_rsp.data_vld) @(negedge axi_s);
        @(posedge axi_s);
        rd_req.data_rdy <= 1'b0;
    endtask

    // compare process, sampled mid-cycle where the ports are settled
    always @(negedge axi_s) begin
        if (rst_n && wr_rsp.resp_vld && wr_req.resp_rdy) begin
            wr_done++;
            if (wr_exp_q.size() == 0) begin
                errors++;
                $display("write response arrived with no write outstanding");
            end else begin
                compare_value({wr_name_q.pop_front(), " resp"}, wr_exp_q.pop_front(),
                              {30'd0, wr_rsp.resp});
            end
        end
        if (rst_n && rd_rsp.data_vld && rd_req.data_rdy) begin
            rd_done++;
            if (rd_exp_data_q.size() == 0) begin
                errors++;
                $display("read data arrived with no read outstanding");
            end else begin
                rd_name = rd_name_q.pop_front();
                compare_value({rd_name, " data"}, rd_exp_data_q.pop_front(), rd_rsp.data);
                compare_value({rd_name, " resp"}, rd_exp_resp_q.pop_front(),
                              {30'd0, rd_rsp.resp});
            end
        end
    end

    // watchdog, budget of 120 transactions
    initial begin
        #(WATCHDOG_TIME);
        errors++;
        $display("timeout: traffic did not finish within %0d time units", WATCHDOG_TIME);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        wr_req <= '0;
        rd_req <= '0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 32'h0;
        end
        shadow[1] = 32'hABCD_1234;
        shadow[3] = 32'h0001_0000;
        wait (rst_n === 1'b1);
        @(negedge axi_s);
        compare_value("idle flags after reset", 32'h0, {27'd0, wr_rsp.addr_rdy,
                      wr_rsp.data_rdy, wr_rsp.resp_vld, rd_rsp.addr_rdy, rd_rsp.data_vld});
        compare_value("read data after reset", 32'h0, rd_rsp.data);

        // reset values of the whole map
        for (int i = 0; i < 16; i++) begin
            do_read(i * 4, 2'd0, $sformatf("reset reg %0d", i));
        end
        // full-word write and readback
        for (int i = 4; i < 16; i++) begin
            rnd = next_rand();
            do_write(i * 4, rnd, 4'hF, rnd[5:4], $sformatf("full write reg %0d", i));
            do_read(i * 4, rnd[9:8], $sformatf("full read reg %0d", i));
        end
        // partial strobes on random rw registers
        for (int i = 0; i < 8; i++) begin
            rnd  = next_rand();
            idx4 = 4'd4 + (rnd[3:0] % 4'd12);
            do_write({26'd0, idx4, 2'b00}, next_rand(), rnd[7:4], rnd[9:8],
                     $sformatf("strobe write %0d", i));
        end
        for (int i = 4; i < 16; i++) begin
            do_read(i * 4, 2'd1, $sformatf("strobe read reg %0d", i));
        end
        // rejected writes, then the map must be untouched
        for (int i = 0; i < 4; i++) begin
            do_write(i * 4, 32'hFFFF_FFFF, 4'hF, 2'd1, $sformatf("ro write reg %0d", i));
        end
        for (int i = 0; i < 8; i++) begin
            do_write(bad_addr[i], 32'h5A5A_5A5A, 4'hF, 2'd0, $sformatf("bad write %0d", i));
        end
        for (int i = 0; i < 16; i++) begin
            do_read(i * 4, 2'd2, $sformatf("after reject reg %0d", i));
        end
        for (int i = 0; i < 8; i++) begin
            do_read(bad_addr[i], 2'd3, $sformatf("bad read %0d", i));
        end

        // mixed traffic, writes on 8..15 and reads on 0..7 so they never race
        for (int i = 0; i < 3 * MIX_N; i++) begin
            mix_rnd[i] = next_rand();
        end
        fork
            for (int k = 0; k < MIX_N; k++) begin
                do_write({26'd0, 1'b1, mix_rnd[3*k][2:0], 1'b0, &mix_rnd[3*k][4:3]},
                         mix_rnd[3*k+1], mix_rnd[3*k][11:8], mix_rnd[3*k][13:12],
                         $sformatf("mixed write %0d", k));
            end
            for (int k = 0; k < MIX_N; k++) begin
                do_read({25'd0, &mix_rnd[3*k+2][4:3], 1'b0, mix_rnd[3*k+2][2:0], 2'b00},
                        mix_rnd[3*k+2][13:12], $sformatf("mixed read %0d", k));
            end
        join
        for (int i = 8; i < 16; i++) begin
            do_read(i * 4, 2'd0, $sformatf("mixed readback reg %0d", i));
        end

        // no lost or duplicated transfers
        compare_value("write transfers", wr_issued, wr_done);
        compare_value("read transfers", rd_issued, rd_done);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/axil_regs_pkg.sv
hw/axil_addr_decode.sv
hw/axil_reg_file.sv
hw/axil_wr_channel.sv
hw/axil_rd_channel.sv
hw/axil_regs_top.sv
verification/tb_clock_gen.sv
verification/axil_regs_checker.sv
verification/tb_axil_regs.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_axil_regs \
    -Mdir obj_dir -o sim_axil_regs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_axil_regs)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
exit 1
